//--- hist_macros.svh
/*
 * Histogram constants: data widths, bin count, burst length and register map
 */
`ifndef HIST_MACROS_SVH
`define HIST_MACROS_SVH

// data widths
`define HIST_PIX_W      8     // sensor pixel
`define HIST_COLOR_W    2     // bayer color, line parity then pixel parity
`define HIST_ADDR_W     10    // color + pixel value
`define HIST_CNT_W      32    // bin counter
`define HIST_DIM_W      16    // window edges and sizes

// readout, one burst per color
`define HIST_BURST_LEN  256

// register addresses, one-bit address space
`define HIST_REG_LEFT_TOP      1'b0  // {top, left}
`define HIST_REG_WIDTH_HEIGHT  1'b1  // {height_m1, width_m1}

`endif

//--- hist_pkg.sv
/*
 * Histogram types shared by the window, configuration and accumulator blocks
 */
`default_nettype none

`include "hist_macros.svh"

package hist_pkg;

    typedef logic [`HIST_PIX_W-1:0]   pix_t;
    typedef logic [`HIST_COLOR_W-1:0] color_t;      // {line parity, pixel parity}
    typedef logic [`HIST_ADDR_W-1:0]  bin_addr_t;   // {color, pixel value}
    typedef logic [`HIST_CNT_W-1:0]   bin_cnt_t;
    typedef logic [`HIST_DIM_W-1:0]   dim_t;

    // window of interest, all values counted from 0 after sof
    typedef struct packed {
        dim_t left;
        dim_t top;
        dim_t width_m1;
        dim_t height_m1;
    } win_cfg_t;

    // one pixel handed from the window logic to the accumulator
    typedef struct packed {
        logic      valid;  // pixel inside the window
        bin_addr_t addr;
    } win_pix_t;

    typedef enum logic [2:0] {
        OFF,
        ARMED,         // enabled, waiting for sof
        TOP_MARGIN,    // lines above the window
        IN_WINDOW,
        WAIT_READOUT   // frame done, bins being read and cleared
    } hist_state_e;

endpackage

`default_nettype wire

//--- hist_cfg_regs.sv
/*
 * Histogram window registers, loaded by a write strobe
 */
`timescale 1ns/1ps
`default_nettype none

`include "hist_macros.svh"

module hist_cfg_regs (
    input  wire                       pclk,
    input  wire                       hist_rst_pclk,
    input  wire                       cfg_wr_i,
    input  wire                       cfg_addr_i,
    input  wire [2*`HIST_DIM_W-1:0]   cfg_data_i,
    input  wire                       hist_active_i,
    output hist_pkg::win_cfg_t        win_cfg_o
);

    logic wr_left_top;
    logic wr_width_height;

    assign wr_left_top     = cfg_wr_i && (cfg_addr_i == `HIST_REG_LEFT_TOP);
    assign wr_width_height = cfg_wr_i && (cfg_addr_i == `HIST_REG_WIDTH_HEIGHT);

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            win_cfg_o <= '0;
        end else begin
            if (wr_left_top) begin
                win_cfg_o.top  <= cfg_data_i[2*`HIST_DIM_W-1:`HIST_DIM_W];
                win_cfg_o.left <= cfg_data_i[`HIST_DIM_W-1:0];
            end
            if (wr_width_height) begin
                win_cfg_o.height_m1 <= cfg_data_i[2*`HIST_DIM_W-1:`HIST_DIM_W];
                win_cfg_o.width_m1  <= cfg_data_i[`HIST_DIM_W-1:0];
            end
        end
    end

    // window edges must stay stable while the window FSM is running
    a_no_cfg_while_active: assert property (
        @(posedge pclk) disable iff (hist_rst_pclk)
        hist_active_i |-> !cfg_wr_i
    ) else $error("window configured while histogram is active");

endmodule

`default_nettype wire

//--- hist_window.sv
/*
 * Histogram window: bayer color, line/pixel counters against the window
 * edges, enable FSM and the frame-done pulse
 */
`timescale 1ns/1ps
`default_nettype none

`include "hist_macros.svh"

module hist_window (
    input  wire                       pclk,
    input  wire                       hist_rst_pclk,
    input  wire                       sof_i,
    input  wire                       hact_i,
    input  wire hist_pkg::pix_t       hist_di_i,
    input  wire                       hist_en_i,
    input  wire                       hist_rst_i,
    input  wire hist_pkg::win_cfg_t   win_cfg_i,
    input  wire                       readout_done_i,
    output hist_pkg::win_pix_t        win_pix_o,
    output logic                      frame_done_o,
    output logic                      hist_active_o
);

    hist_pkg::hist_state_e state;

    logic                  hact_d;
    hist_pkg::dim_t        line_cnt;    // line index since sof
    hist_pkg::dim_t        pix_cnt;     // pixel index in the current line
    hist_pkg::color_t      color;

    logic [`HIST_DIM_W:0]  h_last;      // one bit wider, edge + size may carry
    logic [`HIST_DIM_W:0]  v_last;
    logic                  h_in;
    logic                  v_in;
    logic                  line_end;
    logic                  last_line;
    logic                  counting;
    logic                  pix_valid;

    logic                  pix_valid_r;
    hist_pkg::bin_addr_t   pix_addr_r;

    assign line_end  = hact_d && !hact_i;  // lines counted on hact fall
    assign color     = {line_cnt[0], pix_cnt[0]};

    assign h_last    = {1'b0, win_cfg_i.left} + {1'b0, win_cfg_i.width_m1};
    assign v_last    = {1'b0, win_cfg_i.top} + {1'b0, win_cfg_i.height_m1};
    assign h_in      = (pix_cnt >= win_cfg_i.left) && ({1'b0, pix_cnt} <= h_last);
    assign v_in      = (line_cnt >= win_cfg_i.top) && ({1'b0, line_cnt} <= v_last);
    assign last_line = ({1'b0, line_cnt} == v_last);

    // first window line may still see TOP_MARGIN for a cycle
    assign counting  = (state == hist_pkg::TOP_MARGIN) || (state == hist_pkg::IN_WINDOW);
    assign pix_valid = counting && hact_i && h_in && v_in;

    assign hist_active_o = (state != hist_pkg::OFF);
    assign win_pix_o     = {pix_valid_r, pix_addr_r};

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            hact_d   <= 1'b0;
            line_cnt <= '0;
            pix_cnt  <= '0;
        end else begin
            hact_d <= hact_i;
            if (hact_i) begin
                pix_cnt <= pix_cnt + 1'b1;
            end else begin
                pix_cnt <= '0;
            end
            if (sof_i) begin
                line_cnt <= '0;
            end else if (line_end) begin
                line_cnt <= line_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk || hist_rst_i) begin
            state <= hist_pkg::OFF;   // immediate disable
        end else begin
            unique case (state)
                hist_pkg::OFF: begin
                    if (hist_en_i) state <= hist_pkg::ARMED;
                end
                hist_pkg::ARMED: begin
                    if (!hist_en_i) begin
                        state <= hist_pkg::OFF;  // graceful disable only between frames
                    end else if (sof_i) begin
                        state <= hist_pkg::TOP_MARGIN;
                    end
                end
                hist_pkg::TOP_MARGIN: begin
                    if (v_in) state <= hist_pkg::IN_WINDOW;
                end
                hist_pkg::IN_WINDOW: begin
                    if (line_end && last_line) state <= hist_pkg::WAIT_READOUT;
                end
                hist_pkg::WAIT_READOUT: begin
                    if (readout_done_i) state <= hist_pkg::ARMED;
                end
                default: state <= hist_pkg::OFF;
            endcase
        end
    end

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            frame_done_o <= 1'b0;
            pix_valid_r  <= 1'b0;
        end else begin
            frame_done_o <= !hist_rst_i && (state == hist_pkg::IN_WINDOW)
                            && line_end && last_line;
            pix_valid_r  <= pix_valid;
        end
    end

    always_ff @(posedge pclk) begin
        pix_addr_r <= {color, hist_di_i};
    end

    // the frame must end at the last window line, never run past it
    a_window_ends_at_last_line: assert property (
        @(posedge pclk) disable iff (hist_rst_pclk)
        (state == hist_pkg::IN_WINDOW) |-> ({1'b0, line_cnt} <= v_last)
    ) else $error("window state past the last window line without frame_done");

endmodule

`default_nettype wire

//--- hist_ram.sv
/*
 * Histogram bin memory, 1024 x 32, registered read, write-first on collision
 */
`timescale 1ns/1ps
`default_nettype none

`include "hist_macros.svh"

module hist_ram (
    input  wire                        pclk,
    input  wire hist_pkg::bin_addr_t   rd_addr_i,
    output hist_pkg::bin_cnt_t         rd_data_o,
    input  wire                        wr_en_i,
    input  wire hist_pkg::bin_addr_t   wr_addr_i,
    input  wire hist_pkg::bin_cnt_t    wr_data_i
);

    localparam int unsigned DEPTH = 1 << `HIST_ADDR_W;

    hist_pkg::bin_cnt_t mem [DEPTH] = '{default: '0};  // histogram starts empty

    always_ff @(posedge pclk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    always_ff @(posedge pclk) begin
        if (wr_en_i && (wr_addr_i == rd_addr_i)) begin
            rd_data_o <= wr_data_i;       // new value wins
        end else begin
            rd_data_o <= mem[rd_addr_i];
        end
    end

endmodule

`default_nettype wire

//--- hist_accum.sv
/*
 * Histogram accumulator: read-modify-write increment with forwarding,
 * and the granted burst readout that clears every bin it reads
 */
`timescale 1ns/1ps
`default_nettype none

`include "hist_macros.svh"

module hist_accum (
    input  wire                        pclk,
    input  wire                        hist_rst_pclk,
    input  wire hist_pkg::win_pix_t    win_pix_i,
    input  wire                        frame_done_i,
    input  wire                        hist_grant_i,
    output logic                       hist_rq_o,
    output hist_pkg::bin_cnt_t         hist_do_o,
    output logic                       hist_dv_o,
    output logic                       readout_done_o,
    output hist_pkg::bin_addr_t        ram_rd_addr_o,
    input  wire hist_pkg::bin_cnt_t    ram_rd_data_i,
    output logic                       ram_wr_en_o,
    output hist_pkg::bin_addr_t        ram_wr_addr_o,
    output hist_pkg::bin_cnt_t         ram_wr_data_o
);

    localparam int unsigned BURST_LAST = `HIST_BURST_LEN - 1;

    // increment pipeline, stage 1 has read data, stage 2 writes back
    logic                  s1_valid;
    hist_pkg::bin_addr_t   s1_addr;
    logic                  s2_valid;
    hist_pkg::bin_addr_t   s2_addr;
    hist_pkg::bin_cnt_t    s2_cnt;
    hist_pkg::bin_cnt_t    base_cnt;

    // readout
    logic                  rd_active;   // from frame_done to the last word
    logic                  rq_r;
    logic                  burst_on;    // read issue cycles of a burst
    hist_pkg::bin_addr_t   rd_addr;
    logic                  burst_end;
    logic                  clr_en;
    hist_pkg::bin_addr_t   clr_addr;
    logic                  dv_r;
    logic                  done_r;

    // previous pixel is written this cycle and was missed by our read,
    // older writes are caught by the write-first RAM
    assign base_cnt = (s2_valid && (s2_addr == s1_addr)) ? s2_cnt : ram_rd_data_i;

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= win_pix_i.valid;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge pclk) begin
        s1_addr <= win_pix_i.addr;
        s2_addr <= s1_addr;
        s2_cnt  <= base_cnt + 1'b1;
    end

    assign burst_end = burst_on &&
                       (rd_addr[`HIST_PIX_W-1:0] == BURST_LAST[`HIST_PIX_W-1:0]);

    always_ff @(posedge pclk) begin
        if (hist_rst_pclk) begin
            rd_active <= 1'b0;
            rq_r      <= 1'b0;
            burst_on  <= 1'b0;
            rd_addr   <= '0;
            clr_en    <= 1'b0;
            dv_r      <= 1'b0;
            done_r    <= 1'b0;
        end else begin
            clr_en <= burst_on;                    // clear the word read last cycle
            dv_r   <= burst_on;                    // RAM read latency
            done_r <= burst_end && (&rd_addr);
            if (frame_done_i && !rd_active) begin
                rd_active <= 1'b1;
                rq_r      <= 1'b1;
            end else if (rq_r && hist_grant_i) begin
                rq_r     <= 1'b0;
                burst_on <= 1'b1;
            end else if (burst_end) begin
                burst_on <= 1'b0;
                if (&rd_addr) begin
                    rd_active <= 1'b0;             // color 3 done
                end else begin
                    rq_r <= 1'b1;                  // ask for the next color
                end
            end
            if (burst_on) begin
                rd_addr <= rd_addr + 1'b1;         // wraps to 0 after the last bin
            end
        end
    end

    always_ff @(posedge pclk) begin
        clr_addr <= rd_addr;
    end

    // pixel path and readout never overlap
    assign ram_rd_addr_o = burst_on ? rd_addr : win_pix_i.addr;
    assign ram_wr_en_o   = s2_valid || clr_en;
    assign ram_wr_addr_o = clr_en ? clr_addr : s2_addr;
    assign ram_wr_data_o = clr_en ? '0 : s2_cnt;

    assign hist_rq_o      = rq_r;
    assign hist_dv_o      = dv_r;
    assign hist_do_o      = ram_rd_data_i;
    assign readout_done_o = done_r;

    a_no_pixel_in_readout: assert property (
        @(posedge pclk) disable iff (hist_rst_pclk)
        rd_active |-> !win_pix_i.valid
    ) else $error("window pixel during histogram readout");

endmodule

`default_nettype wire

//--- sens_histogram.sv
/*
 * Per-color sensor histogram over a programmable window, top level
 */
`timescale 1ns/1ps
`default_nettype none

`include "hist_macros.svh"

module sens_histogram (
    input  wire                        pclk,
    input  wire                        hist_rst_pclk,
    input  wire                        sof_i,
    input  wire                        hact_i,
    input  wire hist_pkg::pix_t        hist_di_i,
    input  wire                        hist_en_i,
    input  wire                        hist_rst_i,
    input  wire                        cfg_wr_i,
    input  wire                        cfg_addr_i,
    input  wire [2*`HIST_DIM_W-1:0]    cfg_data_i,
    input  wire                        hist_grant_i,
    output hist_pkg::bin_cnt_t         hist_do_o,
    output logic                       hist_rq_o,
    output logic                       hist_dv_o
);

    hist_pkg::win_cfg_t    win_cfg;
    hist_pkg::win_pix_t    win_pix;
    logic                  hist_active;
    logic                  frame_done;
    logic                  readout_done;

    hist_pkg::bin_addr_t   ram_rd_addr;
    hist_pkg::bin_cnt_t    ram_rd_data;
    logic                  ram_wr_en;
    hist_pkg::bin_addr_t   ram_wr_addr;
    hist_pkg::bin_cnt_t    ram_wr_data;

    hist_cfg_regs u_cfg_regs (
        .pclk          (pclk),
        .hist_rst_pclk (hist_rst_pclk),
        .cfg_wr_i      (cfg_wr_i),
        .cfg_addr_i    (cfg_addr_i),
        .cfg_data_i    (cfg_data_i),
        .hist_active_i (hist_active),
        .win_cfg_o     (win_cfg)
    );

    hist_window u_window (
        .pclk           (pclk),
        .hist_rst_pclk  (hist_rst_pclk),
        .sof_i          (sof_i),
        .hact_i         (hact_i),
        .hist_di_i      (hist_di_i),
        .hist_en_i      (hist_en_i),
        .hist_rst_i     (hist_rst_i),
        .win_cfg_i      (win_cfg),
        .readout_done_i (readout_done),
        .win_pix_o      (win_pix),
        .frame_done_o   (frame_done),
        .hist_active_o  (hist_active)
    );

    hist_accum u_accum (
        .pclk           (pclk),
        .hist_rst_pclk  (hist_rst_pclk),
        .win_pix_i      (win_pix),
        .frame_done_i   (frame_done),
        .hist_grant_i   (hist_grant_i),
        .hist_rq_o      (hist_rq_o),
        .hist_do_o      (hist_do_o),
        .hist_dv_o      (hist_dv_o),
        .readout_done_o (readout_done),
        .ram_rd_addr_o  (ram_rd_addr),
        .ram_rd_data_i  (ram_rd_data),
        .ram_wr_en_o    (ram_wr_en),
        .ram_wr_addr_o  (ram_wr_addr),
        .ram_wr_data_o  (ram_wr_data)
    );

    hist_ram u_ram (
        .pclk      (pclk),
        .rd_addr_i (ram_rd_addr),
        .rd_data_o (ram_rd_data),
        .wr_en_i   (ram_wr_en),
        .wr_addr_i (ram_wr_addr),
        .wr_data_i (ram_wr_data)
    );

endmodule

`default_nettype wire

//--- tb_sens_histogram.sv
/*
 * Sensor histogram testbench: directed frames against a per-bin reference
 * model, with granted burst readout and the enable and grant rules
 */
`timescale 1ns/1ps
`default_nettype none

`include "hist_macros.svh"

module tb_sens_histogram;

    localparam int unsigned SEED    = 32'hac5d_acb5;
    localparam int          BINS    = 1 << `HIST_ADDR_W;
    localparam int          TIMEOUT = 200;          // cycles for any single wait

    logic                       pclk;
    logic                       hist_rst_pclk;
    logic                       sof_i;
    logic                       hact_i;
    hist_pkg::pix_t             hist_di_i;
    logic                       hist_en_i;
    logic                       hist_rst_i;
    logic                       cfg_wr_i;
    logic                       cfg_addr_i;
    logic [2*`HIST_DIM_W-1:0]   cfg_data_i;
    logic                       hist_grant_i;
    hist_pkg::bin_cnt_t         hist_do_o;
    logic                       hist_rq_o;
    logic                       hist_dv_o;

    hist_pkg::win_cfg_t         win;                // window as last written to the DUT
    hist_pkg::bin_cnt_t         model [BINS];       // expected count per bin
    hist_pkg::bin_cnt_t         words [BINS];       // words of the last readout
    int                         checks;
    int                         errors;
    int                         timeouts;

    sens_histogram dut_i (
        .pclk          (pclk),
        .hist_rst_pclk (hist_rst_pclk),
        .sof_i         (sof_i),
        .hact_i        (hact_i),
        .hist_di_i     (hist_di_i),
        .hist_en_i     (hist_en_i),
        .hist_rst_i    (hist_rst_i),
        .cfg_wr_i      (cfg_wr_i),
        .cfg_addr_i    (cfg_addr_i),
        .cfg_data_i    (cfg_data_i),
        .hist_grant_i  (hist_grant_i),
        .hist_do_o     (hist_do_o),
        .hist_rq_o     (hist_rq_o),
        .hist_dv_o     (hist_dv_o)
    );

    initial begin
        pclk = 1'b0;
        forever #4 pclk = ~pclk;                     // 8 ns period
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_true(input bit ok, input string msg);
        checks++;
        assert (ok) else begin
            errors++;
            $display("%s", msg);
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        $display("timeout while waiting for %s", what);
    endtask

    // window rule, lines and pixels counted from 0 after sof
    function automatic bit in_window(input int line, input int pix);
        return (line >= int'(win.top)) && (line <= int'(win.top) + int'(win.height_m1))
            && (pix >= int'(win.left)) && (pix <= int'(win.left) + int'(win.width_m1));
    endfunction

    task automatic configure_window(input hist_pkg::dim_t left, input hist_pkg::dim_t top,
                                    input hist_pkg::dim_t w_m1, input hist_pkg::dim_t h_m1);
        @(negedge pclk);
        hist_en_i  = 1'b0;
        hist_rst_i = 1'b1;                           // force OFF before writing
        @(negedge pclk);
        hist_rst_i = 1'b0;
        cfg_wr_i   = 1'b1;
        cfg_addr_i = `HIST_REG_LEFT_TOP;
        cfg_data_i = {top, left};
        @(negedge pclk);
        cfg_addr_i = `HIST_REG_WIDTH_HEIGHT;
        cfg_data_i = {h_m1, w_m1};
        @(negedge pclk);
        cfg_wr_i   = 1'b0;
        win = '{left: left, top: top, width_m1: w_m1, height_m1: h_m1};
    endtask

    task automatic enable_histogram();
        @(negedge pclk);
        hist_en_i = 1'b1;
        repeat (2) @(negedge pclk);
    endtask

    // rst_line >= 0 pulses hist_rst_i (with enable low) at the start of that line
    task automatic send_frame(input int n_lines, input int n_pix, input bit rand_pix,
                              input hist_pkg::pix_t fill, input bit counted,
                              input int rst_line);
        int l;
        int p;
        hist_pkg::pix_t v;
        hist_pkg::bin_addr_t a;
        @(negedge pclk);
        sof_i = 1'b1;
        @(negedge pclk);
        sof_i = 1'b0;
        repeat (2) @(negedge pclk);
        for (l = 0; l < n_lines; l++) begin
            if (l == rst_line) begin
                hist_rst_i = 1'b1;
                hist_en_i  = 1'b0;
                @(negedge pclk);
                hist_rst_i = 1'b0;
            end
            for (p = 0; p < n_pix; p++) begin
                v = rand_pix ? hist_pkg::pix_t'($urandom) : fill;
                hact_i    = 1'b1;
                hist_di_i = v;
                if (counted && in_window(l, p)) begin
                    a = {l[0], p[0], v};             // color is line then pixel parity
                    model[a] = model[a] + 1;
                end
                @(negedge pclk);
            end
            hact_i    = 1'b0;
            hist_di_i = '0;
            repeat (4) @(negedge pclk);              // line blanking
        end
    endtask

    task automatic wait_for_rq(output bit seen);
        int n;
        seen = 1'b0;
        for (n = 0; n < TIMEOUT && !seen; n++) begin
            @(negedge pclk);
            seen = hist_rq_o;
        end
    endtask

    // four granted bursts, one per color, compared word by word with the model
    task automatic read_histogram();
        bit seen;
        int lat;
        int c;
        int i;
        hist_pkg::bin_addr_t a;
        for (c = 0; c < 4; c++) begin
            wait_for_rq(seen);
            if (!seen) begin
                report_timeout($sformatf("hist_rq_o before burst %0d", c));
                return;
            end
            hist_grant_i = 1'b1;
            lat  = 0;
            seen = 1'b0;
            while (!seen && lat < TIMEOUT) begin
                @(negedge pclk);
                hist_grant_i = 1'b0;
                lat++;
                seen = hist_dv_o;
                if (!seen) check_value("hist_rq_o", hist_rq_o, 0);
            end
            if (!seen) begin
                report_timeout("hist_dv_o after a grant");
                return;
            end
            check_value("grant to hist_dv_o latency", lat, 2);
            for (i = 0; i < `HIST_BURST_LEN; i++) begin
                if (i > 0) @(negedge pclk);
                a = hist_pkg::bin_addr_t'(c * `HIST_BURST_LEN + i);
                check_value("hist_dv_o", hist_dv_o, 1);
                check_value($sformatf("hist_do_o[%03h]", a), hist_do_o, model[a]);
                words[a] = hist_do_o;
                model[a] = '0;                       // read clears the bin
            end
            @(negedge pclk);
            check_value("hist_dv_o", hist_dv_o, 0);  // burst is exactly 256 words
        end
        repeat (8) begin
            @(negedge pclk);
            check_value("hist_rq_o", hist_rq_o, 0);  // no fifth burst
        end
    endtask

    task automatic test_single_pixel();
        int i;
        int hits;
        configure_window(16'd4, 16'd2, 16'd0, 16'd0);
        enable_histogram();
        send_frame(5, 8, 1'b1, '0, 1'b1, -1);
        read_histogram();
        hits = 0;
        for (i = 0; i < BINS; i++) begin
            if (words[i] != 0) begin
                hits++;
                check_true(i < `HIST_BURST_LEN && words[i] == 1,
                           $sformatf("bin %0d is set but is not a single color 0 hit", i));
            end
        end
        check_value("hist_do_o nonzero words", hits, 1);
    endtask

    task automatic test_random_frame();
        configure_window(16'd3, 16'd2, 16'd5, 16'd3);
        enable_histogram();
        send_frame(8, 12, 1'b1, '0, 1'b1, -1);
        read_histogram();
    endtask

    // one line of the same value hits bins 2/5a and 3/5a back to back
    task automatic test_repeated_value();
        configure_window(16'd0, 16'd1, 16'd15, 16'd0);
        enable_histogram();
        send_frame(3, 16, 1'b0, 8'h5a, 1'b1, -1);
        read_histogram();
        check_value("hist_do_o[25a]", words[10'h25a], 8);
        check_value("hist_do_o[35a]", words[10'h35a], 8);
    endtask

    task automatic test_clear_on_read();
        send_frame(3, 16, 1'b0, 8'h5a, 1'b1, -1);  // same window, still armed
        read_histogram();
        check_value("hist_do_o[25a]", words[10'h25a], 8);
        check_value("hist_do_o[35a]", words[10'h35a], 8);
    endtask

    task automatic test_disable();
        bit seen;
        configure_window(16'd0, 16'd3, 16'd7, 16'd1);  // leaves hist_en_i low
        send_frame(6, 8, 1'b1, '0, 1'b0, -1);
        wait_for_rq(seen);
        check_true(!seen, "hist_rq_o rose with hist_en_i low");
        enable_histogram();
        send_frame(6, 8, 1'b1, '0, 1'b0, 1);       // reset hits above the window
        wait_for_rq(seen);
        check_true(!seen, "hist_rq_o rose after hist_rst_i");
        enable_histogram();
        send_frame(6, 8, 1'b1, '0, 1'b1, -1);
        wait_for_rq(seen);
        check_true(seen, "no hist_rq_o after an enabled frame");
        send_frame(6, 8, 1'b1, '0, 1'b0, -1);      // arrives with readout pending
        read_histogram();
    endtask

    task automatic test_grant_rules();
        int n;
        @(negedge pclk);
        hist_grant_i = 1'b1;                         // rq is low here
        @(negedge pclk);
        hist_grant_i = 1'b0;
        for (n = 0; n < 16; n++) begin
            check_value("hist_dv_o", hist_dv_o, 0);
            check_value("hist_rq_o", hist_rq_o, 0);
            @(negedge pclk);
        end
    endtask

    initial begin
        void'($urandom(SEED));
        hist_rst_pclk = 1'b1;
        sof_i         = 1'b0;
        hact_i        = 1'b0;
        hist_di_i     = '0;
        hist_en_i     = 1'b0;
        hist_rst_i    = 1'b0;
        cfg_wr_i      = 1'b0;
        cfg_addr_i    = 1'b0;
        cfg_data_i    = '0;
        hist_grant_i  = 1'b0;
        win           = '0;
        model         = '{default: '0};
        words         = '{default: '0};
        checks        = 0;
        errors        = 0;
        timeouts      = 0;
        repeat (8) @(negedge pclk);
        hist_rst_pclk = 1'b0;

        test_single_pixel();
        test_random_frame();
        test_repeated_value();
        test_clear_on_read();
        test_disable();
        test_grant_rules();

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+.
hist_pkg.sv
hist_cfg_regs.sv
hist_window.sv
hist_ram.sv
hist_accum.sv
sens_histogram.sv
tb_sens_histogram.sv

//--- run.sh
#!/bin/sh
# build and run the sensor histogram testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_sens_histogram -f tb.f

./obj_dir/Vtb_sens_histogram 2>&1 | tee sim.log

if grep -qx "TB PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
